// ==== Bender.yml ====
package:
  name: lite_demux

sources:
  - logic/lite_demux_pkg.sv
  - logic/select_fifo.sv
  - logic/write_router.sv
  - logic/read_router.sv
  - logic/lite_demux_top.sv
  - target: test
    files:
      - tb/sub_port_model.sv
      - tb/tb_lite_demux.sv

// ==== files.f ====
logic/lite_demux_pkg.sv
logic/select_fifo.sv
logic/write_router.sv
logic/read_router.sv
logic/lite_demux_top.sv
tb/sub_port_model.sv
tb/tb_lite_demux.sv

// ==== logic/lite_demux_pkg.sv ====
// --------------------------------------
// shared widths, default counts and the AXI response code
// for the AXI4-Lite demultiplexer
// --------------------------------------
package lite_demux_pkg;

  // --------------------------------------
  // bus widths
  // --------------------------------------
  localparam int unsigned ADDR_WIDTH = 32;
  localparam int unsigned DATA_WIDTH = 32;
  // one strobe bit per data byte
  localparam int unsigned STRB_WIDTH = DATA_WIDTH / 8;

  // --------------------------------------
  // default sizing
  // --------------------------------------
  // subordinate ports behind the demux
  localparam int unsigned DEFAULT_NUM_PORTS = 4;
  // open transactions per path
  localparam int unsigned DEFAULT_MAX_TRANS = 4;

  // --------------------------------------
  // payload types
  // --------------------------------------
  typedef logic [ADDR_WIDTH-1:0] addr_t;
  typedef logic [DATA_WIDTH-1:0] data_t;
  typedef logic [STRB_WIDTH-1:0] strb_t;

  // AXI BRESP / RRESP encoding
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_EXOKAY = 2'b01,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } resp_e;

endpackage

// ==== logic/lite_demux_top.sv ====
`timescale 1ns/1ps
// --------------------------------------
// AXI4-Lite demux, one manager port to NumPorts subordinates
// --------------------------------------
module lite_demux_top #(
  parameter int unsigned  NumPorts = lite_demux_pkg::DEFAULT_NUM_PORTS,
  parameter int unsigned  MaxTrans = lite_demux_pkg::DEFAULT_MAX_TRANS,
  localparam int unsigned IdxWidth = $clog2(NumPorts)
) (
  input  logic                                  clk_i,
  input  logic                                  reset_i,
  // manager side
  input  lite_demux_pkg::addr_t                 aw_addr_i,
  input  logic [IdxWidth-1:0]                   aw_idx_i,
  input  logic                                  aw_valid_i,
  output logic                                  aw_ready_o,
  input  lite_demux_pkg::data_t                 w_data_i,
  input  lite_demux_pkg::strb_t                 w_strb_i,
  input  logic                                  w_valid_i,
  output logic                                  w_ready_o,
  output lite_demux_pkg::resp_e                 b_resp_o,
  output logic                                  b_valid_o,
  input  logic                                  b_ready_i,
  input  lite_demux_pkg::addr_t                 ar_addr_i,
  input  logic [IdxWidth-1:0]                   ar_idx_i,
  input  logic                                  ar_valid_i,
  output logic                                  ar_ready_o,
  output lite_demux_pkg::data_t                 r_data_o,
  output lite_demux_pkg::resp_e                 r_resp_o,
  output logic                                  r_valid_o,
  input  logic                                  r_ready_i,
  // subordinate side
  output lite_demux_pkg::addr_t [NumPorts-1:0] sub_aw_addr_o,
  output logic [NumPorts-1:0]                   sub_aw_valid_o,
  input  logic [NumPorts-1:0]                   sub_aw_ready_i,
  output lite_demux_pkg::data_t [NumPorts-1:0] sub_w_data_o,
  output lite_demux_pkg::strb_t [NumPorts-1:0] sub_w_strb_o,
  output logic [NumPorts-1:0]                   sub_w_valid_o,
  input  logic [NumPorts-1:0]                   sub_w_ready_i,
  input  lite_demux_pkg::resp_e [NumPorts-1:0] sub_b_resp_i,
  input  logic [NumPorts-1:0]                   sub_b_valid_i,
  output logic [NumPorts-1:0]                   sub_b_ready_o,
  output lite_demux_pkg::addr_t [NumPorts-1:0] sub_ar_addr_o,
  output logic [NumPorts-1:0]                   sub_ar_valid_o,
  input  logic [NumPorts-1:0]                   sub_ar_ready_i,
  input  lite_demux_pkg::data_t [NumPorts-1:0] sub_r_data_i,
  input  lite_demux_pkg::resp_e [NumPorts-1:0] sub_r_resp_i,
  input  logic [NumPorts-1:0]                   sub_r_valid_i,
  output logic [NumPorts-1:0]                   sub_r_ready_o
);

  // write and read paths share nothing but the clock and reset
  write_router #(.NumPorts(NumPorts), .MaxTrans(MaxTrans)) wr (
    .clk_i, .reset_i,
    .aw_addr_i, .aw_idx_i, .aw_valid_i, .aw_ready_o,
    .w_data_i, .w_strb_i, .w_valid_i, .w_ready_o,
    .b_resp_o, .b_valid_o, .b_ready_i,
    .sub_aw_addr_o, .sub_aw_valid_o, .sub_aw_ready_i,
    .sub_w_data_o, .sub_w_strb_o, .sub_w_valid_o, .sub_w_ready_i,
    .sub_b_resp_i, .sub_b_valid_i, .sub_b_ready_o
  );

  read_router #(.NumPorts(NumPorts), .MaxTrans(MaxTrans)) rd (
    .clk_i, .reset_i,
    .ar_addr_i, .ar_idx_i, .ar_valid_i, .ar_ready_o,
    .r_data_o, .r_resp_o, .r_valid_o, .r_ready_i,
    .sub_ar_addr_o, .sub_ar_valid_o, .sub_ar_ready_i,
    .sub_r_data_i, .sub_r_resp_i, .sub_r_valid_i, .sub_r_ready_o
  );

endmodule

// ==== logic/read_router.sv ====
`timescale 1ns/1ps
// --------------------------------------
// steers AR to the selected subordinate, returns R in AR order
// --------------------------------------
module read_router #(
  parameter int unsigned  NumPorts = lite_demux_pkg::DEFAULT_NUM_PORTS,
  parameter int unsigned  MaxTrans = lite_demux_pkg::DEFAULT_MAX_TRANS,
  localparam int unsigned IdxWidth = $clog2(NumPorts)
) (
  input  logic                                  clk_i,
  input  logic                                  reset_i,
  // manager side
  input  lite_demux_pkg::addr_t                 ar_addr_i,
  input  logic [IdxWidth-1:0]                   ar_idx_i,
  input  logic                                  ar_valid_i,
  output logic                                  ar_ready_o,
  output lite_demux_pkg::data_t                 r_data_o,
  output lite_demux_pkg::resp_e                 r_resp_o,
  output logic                                  r_valid_o,
  input  logic                                  r_ready_i,
  // subordinate side
  output lite_demux_pkg::addr_t [NumPorts-1:0] sub_ar_addr_o,
  output logic [NumPorts-1:0]                   sub_ar_valid_o,
  input  logic [NumPorts-1:0]                   sub_ar_ready_i,
  input  lite_demux_pkg::data_t [NumPorts-1:0] sub_r_data_i,
  input  lite_demux_pkg::resp_e [NumPorts-1:0] sub_r_resp_i,
  input  logic [NumPorts-1:0]                   sub_r_valid_i,
  output logic [NumPorts-1:0]                   sub_r_ready_o
);

  logic [IdxWidth-1:0] r_sel;
  logic                r_push, r_pop, r_full, r_empty;

  // AR only leaves while there is room to track it
  assign ar_ready_o = ~r_full & sub_ar_ready_i[ar_idx_i];
  assign r_push     = ar_valid_i & ar_ready_o;

  select_fifo #(.Depth(MaxTrans), .IdxWidth(IdxWidth)) r_fifo (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .push_i  (r_push),
    .idx_i   (ar_idx_i),
    .pop_i   (r_pop),
    .idx_o   (r_sel),
    .full_o  (r_full),
    .empty_o (r_empty)
  );

  // response comes from the oldest open read only
  assign r_valid_o = ~r_empty & sub_r_valid_i[r_sel];
  assign r_data_o  = r_empty ? '0 : sub_r_data_i[r_sel];
  assign r_resp_o  = r_empty ? lite_demux_pkg::RESP_OKAY : sub_r_resp_i[r_sel];
  assign r_pop     = r_valid_o & r_ready_i;

  for (genvar i = 0; i < NumPorts; i++) begin : gen_port
    assign sub_ar_addr_o[i]  = ar_addr_i;
    assign sub_ar_valid_o[i] = ~r_full & ar_valid_i & (ar_idx_i == IdxWidth'(i));
    assign sub_r_ready_o[i]  = ~r_empty & r_ready_i & (r_sel == IdxWidth'(i));
  end

  ar_valid_held: assert property (@(posedge clk_i) disable iff (reset_i)
    ar_valid_i && !ar_ready_o |=> ar_valid_i) else $error("ar_valid_i dropped before ready");
  ar_req_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    ar_valid_i && !ar_ready_o |=> $stable(ar_addr_i) && $stable(ar_idx_i))
    else $error("AR request changed while stalled");
  ar_idx_range: assert property (@(posedge clk_i) disable iff (reset_i)
    ar_valid_i |-> ar_idx_i < NumPorts) else $error("ar_idx_i selects no port");

endmodule

// ==== logic/select_fifo.sv ====
`timescale 1ns/1ps
// --------------------------------------
// small FIFO of port indices, one entry per open transaction
// --------------------------------------
module select_fifo #(
  parameter int unsigned Depth    = 4,
  parameter int unsigned IdxWidth = 2
) (
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic                push_i,
  input  logic [IdxWidth-1:0] idx_i,
  input  logic                pop_i,
  output logic [IdxWidth-1:0] idx_o,
  output logic                full_o,
  output logic                empty_o
);

  localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntWidth = $clog2(Depth + 1);

  logic [IdxWidth-1:0] mem_q [Depth];
  logic [PtrWidth-1:0] wr_ptr_q, rd_ptr_q;
  logic [CntWidth-1:0] count_q;
  logic                do_push, do_pop;

  assign full_o  = (count_q == CntWidth'(Depth));
  assign empty_o = (count_q == '0);
  assign idx_o   = mem_q[rd_ptr_q];

  // guard against misuse by the caller
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;

  // storage
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= idx_i;
    end
  end

  // pointers and occupancy
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PtrWidth'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrWidth'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  no_push_when_full: assert property (@(posedge clk_i) disable iff (reset_i)
    push_i |-> !full_o) else $error("select_fifo push while full");
  no_pop_when_empty: assert property (@(posedge clk_i) disable iff (reset_i)
    pop_i |-> !empty_o) else $error("select_fifo pop while empty");

endmodule

// ==== logic/write_router.sv ====
`timescale 1ns/1ps
// --------------------------------------
// steers AW and W to the selected subordinate, returns B in AW order
// --------------------------------------
module write_router #(
  parameter int unsigned  NumPorts = lite_demux_pkg::DEFAULT_NUM_PORTS,
  parameter int unsigned  MaxTrans = lite_demux_pkg::DEFAULT_MAX_TRANS,
  localparam int unsigned IdxWidth = $clog2(NumPorts)
) (
  input  logic                                  clk_i,
  input  logic                                  reset_i,
  // manager side
  input  lite_demux_pkg::addr_t                 aw_addr_i,
  input  logic [IdxWidth-1:0]                   aw_idx_i,
  input  logic                                  aw_valid_i,
  output logic                                  aw_ready_o,
  input  lite_demux_pkg::data_t                 w_data_i,
  input  lite_demux_pkg::strb_t                 w_strb_i,
  input  logic                                  w_valid_i,
  output logic                                  w_ready_o,
  output lite_demux_pkg::resp_e                 b_resp_o,
  output logic                                  b_valid_o,
  input  logic                                  b_ready_i,
  // subordinate side
  output lite_demux_pkg::addr_t [NumPorts-1:0] sub_aw_addr_o,
  output logic [NumPorts-1:0]                   sub_aw_valid_o,
  input  logic [NumPorts-1:0]                   sub_aw_ready_i,
  output lite_demux_pkg::data_t [NumPorts-1:0] sub_w_data_o,
  output lite_demux_pkg::strb_t [NumPorts-1:0] sub_w_strb_o,
  output logic [NumPorts-1:0]                   sub_w_valid_o,
  input  logic [NumPorts-1:0]                   sub_w_ready_i,
  input  lite_demux_pkg::resp_e [NumPorts-1:0] sub_b_resp_i,
  input  logic [NumPorts-1:0]                   sub_b_valid_i,
  output logic [NumPorts-1:0]                   sub_b_ready_o
);

  typedef enum logic {
    AW_IDLE,
    AW_LOCKED
  } aw_state_e;

  aw_state_e           aw_state_q, aw_state_d;
  logic [IdxWidth-1:0] w_sel, b_sel;
  logic                w_push, w_pop, w_full, w_empty;
  logic                b_pop, b_full, b_empty;
  logic                w_open;

  // --------------------------------------
  // AW stage
  // --------------------------------------
  // index goes into the W FIFO on the first cycle of the request,
  // the locked state keeps valid up without a second push
  always_comb begin
    aw_state_d     = aw_state_q;
    aw_ready_o     = 1'b0;
    w_push         = 1'b0;
    sub_aw_valid_o = '0;
    case (aw_state_q)
      AW_IDLE: begin
        if (aw_valid_i && !w_full) begin
          w_push                   = 1'b1;
          sub_aw_valid_o[aw_idx_i] = 1'b1;
          if (sub_aw_ready_i[aw_idx_i]) begin
            aw_ready_o = 1'b1;
          end else begin
            aw_state_d = AW_LOCKED;
          end
        end
      end
      AW_LOCKED: begin
        sub_aw_valid_o[aw_idx_i] = 1'b1;
        if (sub_aw_ready_i[aw_idx_i]) begin
          aw_ready_o = 1'b1;
          aw_state_d = AW_IDLE;
        end
      end
      default: aw_state_d = AW_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      aw_state_q <= AW_IDLE;
    end else begin
      aw_state_q <= aw_state_d;
    end
  end

  select_fifo #(.Depth(MaxTrans), .IdxWidth(IdxWidth)) w_fifo (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .push_i  (w_push),
    .idx_i   (aw_idx_i),
    .pop_i   (w_pop),
    .idx_o   (w_sel),
    .full_o  (w_full),
    .empty_o (w_empty)
  );

  // --------------------------------------
  // W and B stages
  // --------------------------------------
  // a W beat needs a known target and room for its response
  assign w_open    = ~w_empty & ~b_full;
  assign w_ready_o = w_open & sub_w_ready_i[w_sel];
  assign w_pop     = w_valid_i & w_ready_o;

  // on W transfer the index moves on to the B FIFO
  select_fifo #(.Depth(MaxTrans), .IdxWidth(IdxWidth)) b_fifo (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .push_i  (w_pop),
    .idx_i   (w_sel),
    .pop_i   (b_pop),
    .idx_o   (b_sel),
    .full_o  (b_full),
    .empty_o (b_empty)
  );

  assign b_valid_o = ~b_empty & sub_b_valid_i[b_sel];
  assign b_resp_o  = b_empty ? lite_demux_pkg::RESP_OKAY : sub_b_resp_i[b_sel];
  assign b_pop     = b_valid_o & b_ready_i;

  for (genvar i = 0; i < NumPorts; i++) begin : gen_port
    assign sub_aw_addr_o[i] = aw_addr_i;
    assign sub_w_data_o[i]  = w_data_i;
    assign sub_w_strb_o[i]  = w_strb_i;
    assign sub_w_valid_o[i] = w_open & w_valid_i & (w_sel == IdxWidth'(i));
    assign sub_b_ready_o[i] = ~b_empty & b_ready_i & (b_sel == IdxWidth'(i));
  end

  aw_valid_held: assert property (@(posedge clk_i) disable iff (reset_i)
    aw_valid_i && !aw_ready_o |=> aw_valid_i) else $error("aw_valid_i dropped before ready");
  aw_req_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    aw_valid_i && !aw_ready_o |=> $stable(aw_addr_i) && $stable(aw_idx_i))
    else $error("AW request changed while stalled");
  aw_idx_range: assert property (@(posedge clk_i) disable iff (reset_i)
    aw_valid_i |-> aw_idx_i < NumPorts) else $error("aw_idx_i selects no port");

endmodule

// ==== tb/sub_port_model.sv ====
`timescale 1ns/1ps
// --------------------------------------
// behavioral AXI4-Lite subordinate, answers requests in order after random delays
// --------------------------------------
module sub_port_model #(
  parameter int unsigned PortIdx = 0
) (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  stall_i,
  input  logic                  aw_valid_i,
  output logic                  aw_ready_o,
  input  logic                  w_valid_i,
  output logic                  w_ready_o,
  output lite_demux_pkg::resp_e b_resp_o,
  output logic                  b_valid_o,
  input  logic                  b_ready_i,
  input  lite_demux_pkg::addr_t ar_addr_i,
  input  logic                  ar_valid_i,
  output logic                  ar_ready_o,
  output lite_demux_pkg::data_t r_data_o,
  output lite_demux_pkg::resp_e r_resp_o,
  output logic                  r_valid_o,
  input  logic                  r_ready_i
);

  // even ports answer OKAY, odd ports SLVERR
  localparam lite_demux_pkg::resp_e PortResp =
    PortIdx[0] ? lite_demux_pkg::RESP_SLVERR : lite_demux_pkg::RESP_OKAY;

  lite_demux_pkg::addr_t rd_q[$];
  int unsigned           aw_cnt, w_cnt, b_cnt;
  logic                  b_busy, r_busy;
  logic [31:0]           seed;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  initial begin
    seed       = 32'h941c + PortIdx;
    aw_ready_o = 1'b0;
    w_ready_o  = 1'b0;
    ar_ready_o = 1'b0;
    b_valid_o  = 1'b0;
    b_resp_o   = PortResp;
    r_valid_o  = 1'b0;
    r_resp_o   = PortResp;
    r_data_o   = '0;
  end

  // --------------------------------------
  // transfers seen on the rising edge
  // --------------------------------------
  always @(posedge clk_i) begin
    if (reset_i) begin
      aw_cnt = 0;
      w_cnt  = 0;
      b_cnt  = 0;
      b_busy = 1'b0;
      r_busy = 1'b0;
      rd_q.delete();
    end else begin
      if (aw_valid_i && aw_ready_o) aw_cnt++;
      if (w_valid_i && w_ready_o) w_cnt++;
      if (b_valid_o && b_ready_i) begin
        b_cnt++;
        b_busy = 1'b0;
      end
      if (r_valid_o && r_ready_i && rd_q.size() > 0) begin
        void'(rd_q.pop_front());
        r_busy = 1'b0;
      end
      if (ar_valid_i && ar_ready_o) rd_q.push_back(ar_addr_i);
    end
  end

  // --------------------------------------
  // outputs change on the falling edge
  // --------------------------------------
  always @(negedge clk_i) begin
    seed = lcg_next(seed);
    if (reset_i) begin
      aw_ready_o = 1'b0;
      w_ready_o  = 1'b0;
      ar_ready_o = 1'b0;
      b_valid_o  = 1'b0;
      r_valid_o  = 1'b0;
    end else begin
      aw_ready_o = seed[17];
      w_ready_o  = seed[18];
      ar_ready_o = seed[19];
      // a write answers once both its AW and W are in
      if (!b_busy && !stall_i && aw_cnt > b_cnt && w_cnt > b_cnt && seed[21:20] == 2'd0)
        b_busy = 1'b1;
      if (!r_busy && !stall_i && rd_q.size() > 0 && seed[23:22] == 2'd0)
        r_busy = 1'b1;
      b_valid_o = b_busy;
      r_valid_o = r_busy;
      r_data_o  = r_busy ? (rd_q[0] ^ (32'(PortIdx) << 28)) : '0;
    end
  end

endmodule

// ==== tb/tb_lite_demux.sv ====
`timescale 1ns/1ps
// --------------------------------------
// testbench for the AXI4-Lite demux with random traffic to four model subordinates
// --------------------------------------
module tb_lite_demux;

  localparam int unsigned NUM_PORTS = 4;
  localparam int unsigned MAX_TRANS = 4;
  localparam int unsigned IDX_W     = $clog2(NUM_PORTS);
  localparam int unsigned TIMEOUT   = 200;
  localparam int unsigned CH_AW     = 0;
  localparam int unsigned CH_W      = 1;
  localparam int unsigned CH_AR     = 2;

  logic                  clk_i = 1'b0;
  logic                  reset_i, stall;
  lite_demux_pkg::addr_t aw_addr_i, ar_addr_i;
  logic [IDX_W-1:0]      aw_idx_i, ar_idx_i;
  logic                  aw_valid_i, aw_ready_o, w_valid_i, w_ready_o, b_valid_o;
  logic                  ar_valid_i, ar_ready_o, r_valid_o;
  logic                  b_ready_i = 1'b0;
  logic                  r_ready_i = 1'b0;
  lite_demux_pkg::data_t w_data_i, r_data_o;
  lite_demux_pkg::strb_t w_strb_i;
  lite_demux_pkg::resp_e b_resp_o, r_resp_o;
  lite_demux_pkg::addr_t [NUM_PORTS-1:0] sub_aw_addr_o, sub_ar_addr_o;
  lite_demux_pkg::data_t [NUM_PORTS-1:0] sub_w_data_o, sub_r_data_i;
  lite_demux_pkg::strb_t [NUM_PORTS-1:0] sub_w_strb_o;
  lite_demux_pkg::resp_e [NUM_PORTS-1:0] sub_b_resp_i, sub_r_resp_i;
  logic [NUM_PORTS-1:0]  sub_aw_valid_o, sub_aw_ready_i, sub_w_valid_o, sub_w_ready_i;
  logic [NUM_PORTS-1:0]  sub_b_valid_i, sub_b_ready_o, sub_ar_valid_o, sub_ar_ready_i;
  logic [NUM_PORTS-1:0]  sub_r_valid_i, sub_r_ready_o;

  // scoreboard of expected responses in issue order
  lite_demux_pkg::resp_e b_q[$];
  logic [33:0]           r_q[$];
  lite_demux_pkg::resp_e exp_b_resp;
  logic [33:0]           exp_r;
  int                    wr_open = 0;
  int                    rd_open = 0;
  logic [IDX_W-1:0]      cur_wport;
  lite_demux_pkg::addr_t cur_waddr;
  lite_demux_pkg::data_t cur_wdata;
  lite_demux_pkg::strb_t cur_wstrb;
  logic [IDX_W-1:0]      cur_rport;
  lite_demux_pkg::addr_t cur_raddr;
  logic [31:0]           seed;
  logic [31:0]           ready_seed = 32'h941c + 32'd16;

  always #2 clk_i = ~clk_i;

  lite_demux_top #(.NumPorts(NUM_PORTS), .MaxTrans(MAX_TRANS)) dut (.*);

  for (genvar p = 0; p < NUM_PORTS; p++) begin : gen_sub
    sub_port_model #(.PortIdx(p)) sub (
      .clk_i, .reset_i, .stall_i(stall),
      .aw_valid_i(sub_aw_valid_o[p]), .aw_ready_o(sub_aw_ready_i[p]),
      .w_valid_i(sub_w_valid_o[p]), .w_ready_o(sub_w_ready_i[p]),
      .b_resp_o(sub_b_resp_i[p]), .b_valid_o(sub_b_valid_i[p]), .b_ready_i(sub_b_ready_o[p]),
      .ar_addr_i(sub_ar_addr_o[p]), .ar_valid_i(sub_ar_valid_o[p]),
      .ar_ready_o(sub_ar_ready_i[p]), .r_data_o(sub_r_data_i[p]),
      .r_resp_o(sub_r_resp_i[p]), .r_valid_o(sub_r_valid_i[p]), .r_ready_i(sub_r_ready_o[p])
    );
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic lite_demux_pkg::resp_e port_resp(input logic [IDX_W-1:0] port);
    return port[0] ? lite_demux_pkg::RESP_SLVERR : lite_demux_pkg::RESP_OKAY;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test FAILED");
    $fatal(1);
  endtask

  task automatic value_error(input string name, input logic [63:0] got, input logic [63:0] exp);
    abort_run($sformatf("ERROR %s got %h expected %h", name, got, exp));
  endtask

  // --------------------------------------
  // checks
  // --------------------------------------
  quiet_in_reset: assert property (@(posedge clk_i) $past(reset_i) |->
    (sub_aw_valid_o == '0 && sub_w_valid_o == '0 && sub_ar_valid_o == '0
     && !b_valid_o && !r_valid_o))
    else abort_run("a valid was high during or right after reset");
  aw_port: assert property (@(posedge clk_i) disable iff (reset_i)
    (sub_aw_valid_o & ~(NUM_PORTS'(1) << cur_wport)) == '0)
    else abort_run("AW valid raised at a port that was not selected");
  aw_addr: assert property (@(posedge clk_i) disable iff (reset_i)
    sub_aw_valid_o[cur_wport] |-> sub_aw_addr_o[cur_wport] == cur_waddr)
    else value_error("sub_aw_addr_o", $sampled(sub_aw_addr_o[cur_wport]), $sampled(cur_waddr));
  w_port: assert property (@(posedge clk_i) disable iff (reset_i)
    (sub_w_valid_o & ~(NUM_PORTS'(1) << cur_wport)) == '0)
    else abort_run("W valid raised at a port other than its AW port");
  w_beat: assert property (@(posedge clk_i) disable iff (reset_i)
    sub_w_valid_o[cur_wport] |->
    {sub_w_data_o[cur_wport], sub_w_strb_o[cur_wport]} == {cur_wdata, cur_wstrb})
    else value_error("sub_w_data_o/sub_w_strb_o",
      $sampled({sub_w_data_o[cur_wport], sub_w_strb_o[cur_wport]}),
      $sampled({cur_wdata, cur_wstrb}));
  ar_port: assert property (@(posedge clk_i) disable iff (reset_i)
    (sub_ar_valid_o & ~(NUM_PORTS'(1) << cur_rport)) == '0)
    else abort_run("AR valid raised at a port that was not selected");
  ar_addr: assert property (@(posedge clk_i) disable iff (reset_i)
    sub_ar_valid_o[cur_rport] |-> sub_ar_addr_o[cur_rport] == cur_raddr)
    else value_error("sub_ar_addr_o", $sampled(sub_ar_addr_o[cur_rport]), $sampled(cur_raddr));
  b_handshake_match: assert property (@(posedge clk_i) disable iff (reset_i)
    $countones(sub_b_valid_i & sub_b_ready_o) == (b_valid_o && b_ready_i))
    else abort_run("B transfers at the subordinates do not match the manager side");
  r_handshake_match: assert property (@(posedge clk_i) disable iff (reset_i)
    $countones(sub_r_valid_i & sub_r_ready_o) == (r_valid_o && r_ready_i))
    else abort_run("R transfers at the subordinates do not match the manager side");
  b_once: assert property (@(posedge clk_i) disable iff (reset_i)
    b_valid_o && b_ready_i |-> wr_open > 0)
    else abort_run("B response arrived with no open write");
  b_in_order: assert property (@(posedge clk_i) disable iff (reset_i)
    b_valid_o && b_ready_i |-> b_resp_o == exp_b_resp)
    else value_error("b_resp_o", $sampled(b_resp_o), $sampled(exp_b_resp));
  r_once: assert property (@(posedge clk_i) disable iff (reset_i)
    r_valid_o && r_ready_i |-> rd_open > 0)
    else abort_run("R response arrived with no open read");
  r_in_order: assert property (@(posedge clk_i) disable iff (reset_i)
    r_valid_o && r_ready_i |-> {r_resp_o, r_data_o} == exp_r)
    else value_error("r_resp_o/r_data_o", $sampled({r_resp_o, r_data_o}), $sampled(exp_r));
  ar_limit: assert property (@(posedge clk_i) disable iff (reset_i)
    ar_valid_i && ar_ready_o |-> rd_open < MAX_TRANS)
    else abort_run("a read was accepted beyond the outstanding limit");

  // open counts and queue heads follow the manager-side transfers
  always @(posedge clk_i) begin
    if (reset_i) begin
      wr_open = 0;
      rd_open = 0;
    end else begin
      if (w_valid_i && w_ready_o) wr_open++;
      if (ar_valid_i && ar_ready_o) rd_open++;
      if (b_valid_o && b_ready_i && b_q.size() > 0) begin
        wr_open--;
        void'(b_q.pop_front());
      end
      if (r_valid_o && r_ready_i && r_q.size() > 0) begin
        rd_open--;
        void'(r_q.pop_front());
      end
    end
    if (b_q.size() > 0) exp_b_resp = b_q[0];
    if (r_q.size() > 0) exp_r = r_q[0];
  end

  // random back-pressure on B and R
  always @(negedge clk_i) begin
    ready_seed = lcg_next(ready_seed);
    b_ready_i  = ready_seed[20] | ready_seed[21];
    r_ready_i  = ready_seed[22] | ready_seed[23];
  end

  // --------------------------------------
  // stimulus
  // --------------------------------------
  task automatic wait_accept(input int unsigned ch, input string name);
    int unsigned cycles;
    logic        done;
    cycles = 0;
    done   = 1'b0;
    while (!done) begin
      @(posedge clk_i);
      case (ch)
        CH_AW:   done = aw_valid_i && aw_ready_o;
        CH_W:    done = w_valid_i && w_ready_o;
        default: done = ar_valid_i && ar_ready_o;
      endcase
      cycles++;
      if (!done && cycles > TIMEOUT) abort_run({name, " request was never accepted"});
    end
  endtask

  task automatic send_write(input logic [IDX_W-1:0] port, input lite_demux_pkg::addr_t addr,
                            input lite_demux_pkg::data_t data,
                            input lite_demux_pkg::strb_t strb);
    @(negedge clk_i);
    cur_wport  = port;
    cur_waddr  = addr;
    aw_idx_i   = port;
    aw_addr_i  = addr;
    aw_valid_i = 1'b1;
    b_q.push_back(port_resp(port));
    wait_accept(CH_AW, "AW");
    @(negedge clk_i);
    aw_valid_i = 1'b0;
    cur_wdata  = data;
    cur_wstrb  = strb;
    w_data_i   = data;
    w_strb_i   = strb;
    w_valid_i  = 1'b1;
    wait_accept(CH_W, "W");
    @(negedge clk_i);
    w_valid_i = 1'b0;
  endtask

  task automatic drive_read(input logic [IDX_W-1:0] port, input lite_demux_pkg::addr_t addr);
    @(negedge clk_i);
    cur_rport  = port;
    cur_raddr  = addr;
    ar_idx_i   = port;
    ar_addr_i  = addr;
    ar_valid_i = 1'b1;
    // model rule is the address with the port index in the top nibble
    r_q.push_back({port_resp(port), addr ^ (32'(port) << 28)});
  endtask

  task automatic send_read(input logic [IDX_W-1:0] port, input lite_demux_pkg::addr_t addr);
    drive_read(port, addr);
    wait_accept(CH_AR, "AR");
    @(negedge clk_i);
    ar_valid_i = 1'b0;
  endtask

  task automatic drain();
    int unsigned cycles;
    cycles = 0;
    while (b_q.size() > 0 || r_q.size() > 0) begin
      @(negedge clk_i);
      cycles++;
      if (cycles > TIMEOUT * 4) abort_run("open transactions did not complete");
    end
  endtask

  initial begin
    reset_i    = 1'b1;
    stall      = 1'b0;
    aw_addr_i  = '0;
    aw_idx_i   = '0;
    aw_valid_i = 1'b0;
    w_data_i   = '0;
    w_strb_i   = '0;
    w_valid_i  = 1'b0;
    ar_addr_i  = '0;
    ar_idx_i   = '0;
    ar_valid_i = 1'b0;
    cur_wport  = '0;
    cur_waddr  = '0;
    cur_wdata  = '0;
    cur_wstrb  = '0;
    cur_rport  = '0;
    cur_raddr  = '0;
    seed       = 32'h941c;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;

    // mixed reads and writes to random ports
    for (int n = 0; n < 40; n++) begin
      seed = lcg_next(seed);
      if (seed[16])
        send_write(seed[21:20], {seed[31:2], 2'b00}, ~seed, seed[27:24]);
      else
        send_read(seed[21:20], {seed[31:2], 2'b00});
    end
    drain();

    // models hold their responses so the fifth read has to wait for room
    @(negedge clk_i);
    stall = 1'b1;
    for (int n = 0; n < MAX_TRANS; n++) begin
      send_read(IDX_W'(n), 32'h0000_1000 + 32'(n) * 4);
    end
    drive_read(2'd1, 32'h0000_2000);
    repeat (20) @(negedge clk_i);
    stall = 1'b0;
    wait_accept(CH_AR, "AR");
    @(negedge clk_i);
    ar_valid_i = 1'b0;
    drain();

    $display("Test OK");
    $finish;
  end

endmodule
